/* exu_core.f */
verilog/rv_isa_pkg.sv
verilog/exu_pkg.sv
verilog/idu_decoder.sv
verilog/gpr_file.sv
verilog/exu_alu_bjp.sv
verilog/wbu_commit.sv
verilog/exu_core_top.sv
tests/tb_exu_core.sv

/* Bender.yml */
package:
  name: exu_core

sources:
  - verilog/rv_isa_pkg.sv
  - verilog/exu_pkg.sv
  - verilog/idu_decoder.sv
  - verilog/gpr_file.sv
  - verilog/exu_alu_bjp.sv
  - verilog/wbu_commit.sv
  - verilog/exu_core_top.sv
  - target: test
    files:
      - tests/tb_exu_core.sv

/* tests/tb_exu_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_exu_core;

  import rv_isa_pkg::*;
  import exu_pkg::*;

  // roughly 560 instructions at two cycles each, with a wide margin
  localparam int MAX_CYCLES = 3000;
  localparam logic [4:0] TMP = 5'd31;

  logic            clk;
  logic            rst_n_i;
  logic            inst_valid_i;
  logic [31:0]     inst_i;
  logic [XLEN-1:0] pc_i;
  commit_t         commit_o;
  logic            halted_o;

  logic [XLEN-1:0] model [32];
  logic [XLEN-1:0] pc_next;
  int              cycles = 0;

  exu_core_top UUT (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .commit_o     (commit_o),
    .halted_o     (halted_o)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $fatal(1);
    end
  end

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input opcode_e opc, input logic [11:0] imm,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type(input opcode_e opc, input logic [19:0] imm,
                                         input logic [4:0] rd);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // ISA result of the OP / OP_IMM funct3 table
  function automatic logic [XLEN-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    case (f3)
      F3_ADD:  return alt ? a - b : a + b;
      F3_SLL:  return a << b[5:0];
      F3_SLT:  return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
      F3_SLTU: return (a < b) ? XLEN'(1) : XLEN'(0);
      F3_XOR:  return a ^ b;
      F3_SR: begin
        if (alt) begin
          return $signed(a) >>> b[5:0];
        end
        return a >> b[5:0];
      end
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // reference model of one instruction against the model registers
  task automatic predict(input logic [31:0] inst, input logic [XLEN-1:0] pc,
                         output commit_t exp, output logic has_res, output logic has_target);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [2:0]      f3;
    logic            ok;
    a          = model[inst[19:15]];
    b          = model[inst[24:20]];
    f3         = inst[14:12];
    imm_i      = {{52{inst[31]}}, inst[31:20]};
    imm_u      = {{32{inst[31]}}, inst[31:12], 12'b0};
    imm_b      = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j      = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    exp        = '0;
    exp.valid  = 1'b1;
    exp.rd_idx = inst[11:7];
    has_res    = 1'b0;
    has_target = 1'b0;
    ok         = 1'b1;
    case (inst[6:0])
      OPC_OP: begin
        ok = (inst[31:25] == F7_BASE) ||
             (inst[31:25] == F7_ALT && (f3 == F3_ADD || f3 == F3_SR));
        has_res     = 1'b1;
        exp.rd_data = alu_model(f3, inst[30], a, b);
      end
      OPC_OP_IMM: begin
        ok = !(f3 == F3_SLL && inst[31:26] != 6'h00) &&
             !(f3 == F3_SR && inst[31:26] != 6'h00 && inst[31:26] != 6'h10);
        has_res     = 1'b1;
        exp.rd_data = alu_model(f3, f3 == F3_SR && inst[30], a, imm_i);
      end
      OPC_LUI: begin
        has_res     = 1'b1;
        exp.rd_data = imm_u;
      end
      OPC_AUIPC: begin
        has_res     = 1'b1;
        exp.rd_data = pc + imm_u;
      end
      OPC_JAL, OPC_JALR: begin
        ok            = (inst[6:0] == OPC_JAL) || (f3 == 3'b000);
        has_res       = 1'b1;
        has_target    = 1'b1;
        exp.rd_data   = pc + 4;
        exp.jump_flag = 1'b1;
        exp.jump_addr = (inst[6:0] == OPC_JAL) ? pc + imm_j : (a + imm_i) & ~XLEN'(1);
      end
      OPC_BRANCH: begin
        ok            = (f3 != 3'b010) && (f3 != 3'b011);
        has_target    = 1'b1;
        exp.jump_flag = branch_taken(f3, a, b);
        exp.jump_addr = pc + imm_b;
      end
      OPC_SYSTEM: ok = (inst == EBREAK_WORD);
      default:    ok = 1'b0;
    endcase
    if (!ok) begin
      exp         = '0;
      exp.valid   = 1'b1;
      exp.rd_idx  = inst[11:7];
      exp.illegal = 1'b1;
      has_res     = 1'b0;
      has_target  = 1'b0;
    end else begin
      exp.rd_wr_en = has_res && (exp.rd_idx != 5'd0);
    end
  endtask

  task automatic expect_eq(input string name, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] got);
    assert (got === exp) else begin
      $display("Fail at %0t: %s expected %h observed %h", $time, name, exp, got);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic flag_eq(input string name, input logic exp, input logic got);
    assert (got === exp) else begin
      $display("Fail at %0t: %s expected %b observed %b", $time, name, exp, got);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n_i      <= 1'b0;
    inst_valid_i <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;
    foreach (model[i]) begin
      model[i] = '0;
    end
    @(negedge clk);
    flag_eq("commit_o.valid", 1'b0, commit_o.valid);
    flag_eq("commit_o.rd_wr_en", 1'b0, commit_o.rd_wr_en);
    flag_eq("halted_o", 1'b0, halted_o);
  endtask

  // one strobe, commit is visible during the following cycle
  task automatic issue_and_check(input logic [31:0] inst);
    commit_t exp;
    logic    has_res;
    logic    has_target;
    predict(inst, pc_next, exp, has_res, has_target);
    @(posedge clk);
    inst_valid_i <= 1'b1;
    inst_i       <= inst;
    pc_i         <= pc_next;
    @(posedge clk);
    inst_valid_i <= 1'b0;
    @(negedge clk);
    flag_eq("commit_o.valid", exp.valid, commit_o.valid);
    flag_eq("commit_o.rd_wr_en", exp.rd_wr_en, commit_o.rd_wr_en);
    expect_eq("commit_o.rd_idx", XLEN'(exp.rd_idx), XLEN'(commit_o.rd_idx));
    flag_eq("commit_o.illegal", exp.illegal, commit_o.illegal);
    flag_eq("commit_o.jump_flag", exp.jump_flag, commit_o.jump_flag);
    flag_eq("halted_o", inst == EBREAK_WORD, halted_o);
    if (has_res) begin
      expect_eq("commit_o.rd_data", exp.rd_data, commit_o.rd_data);
    end
    if (has_target) begin
      expect_eq("commit_o.jump_addr", exp.jump_addr, commit_o.jump_addr);
    end
    if (exp.rd_wr_en) begin
      model[exp.rd_idx] = exp.rd_data;
    end
    pc_next = pc_next + 4;
  endtask

  task automatic strobe_while_halted(input logic [31:0] inst);
    @(posedge clk);
    inst_valid_i <= 1'b1;
    inst_i       <= inst;
    pc_i         <= pc_next;
    @(posedge clk);
    inst_valid_i <= 1'b0;
    @(negedge clk);
    flag_eq("commit_o.valid", 1'b0, commit_o.valid);
    flag_eq("halted_o", 1'b1, halted_o);
  endtask

  // model follows the sign extension of lui and addi
  task automatic load_reg(input logic [4:0] rd);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $urandom;
    lo = $urandom;
    issue_and_check(u_type(OPC_LUI, hi[31:12], rd));
    issue_and_check(i_type(OPC_OP_IMM, hi[11:0], rd, F3_ADD, rd));
    issue_and_check(i_type(OPC_OP_IMM, 12'd32, rd, F3_SLL, rd));
    issue_and_check(u_type(OPC_LUI, lo[31:12], TMP));
    issue_and_check(i_type(OPC_OP_IMM, lo[11:0], TMP, F3_ADD, TMP));
    issue_and_check(i_type(OPC_OP_IMM, 12'd32, TMP, F3_SLL, TMP));
    issue_and_check(i_type(OPC_OP_IMM, 12'd32, TMP, F3_SR, TMP));
    issue_and_check(r_type(F7_BASE, TMP, rd, F3_OR, rd));
  endtask

  task automatic reset_reads_zero();
    for (int r = 0; r < 32; r++) begin
      issue_and_check(r_type(F7_BASE, 5'd0, 5'(r), F3_ADD, 5'd1));
    end
  endtask

  task automatic random_alu_ops();
    logic [31:0] r;
    logic [31:0] v;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    for (int i = 1; i < 31; i++) begin
      load_reg(5'(i));
    end
    for (int n = 0; n < 200; n++) begin
      r   = $urandom;
      v   = $urandom;
      rd  = 5'(1 + r[4:0] % 30);
      rs1 = 5'(r[9:5] % 31);
      rs2 = 5'(r[14:10] % 31);
      f3  = r[17:15];
      alt = r[21] && (f3 == F3_ADD || f3 == F3_SR);
      imm = v[11:0];
      if (f3 == F3_SLL || f3 == F3_SR) begin
        imm = {1'b0, r[21] && f3 == F3_SR, 4'b0, v[5:0]};
      end
      case (r[20:18])
        3'd0, 3'd1, 3'd2: issue_and_check(r_type(alt ? F7_ALT : F7_BASE, rs2, rs1, f3, rd));
        3'd3, 3'd4, 3'd5: issue_and_check(i_type(OPC_OP_IMM, imm, rs1, f3, rd));
        3'd6:             issue_and_check(u_type(OPC_LUI, v[31:12], rd));
        default:          issue_and_check(u_type(OPC_AUIPC, v[31:12], rd));
      endcase
    end
  endtask

  task automatic x0_write_ignored();
    issue_and_check(r_type(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd0));
    issue_and_check(i_type(OPC_OP_IMM, 12'h7ff, 5'd3, F3_XOR, 5'd0));
    issue_and_check(u_type(OPC_LUI, 20'habcde, 5'd0));
    issue_and_check(r_type(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd5));
    issue_and_check(r_type(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd6));
  endtask

  task automatic branch_and_jump();
    logic [2:0]  br_f3 [6];
    logic [4:0]  lhs [5];
    logic [4:0]  rhs [5];
    logic [31:0] r;
    br_f3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    // equal, less, greater, then mixed signs both ways
    lhs   = '{5'd10, 5'd10, 5'd12, 5'd14, 5'd15};
    rhs   = '{5'd11, 5'd12, 5'd10, 5'd15, 5'd14};
    load_reg(5'd10);
    issue_and_check(r_type(F7_BASE, 5'd0, 5'd10, F3_ADD, 5'd11));
    issue_and_check(i_type(OPC_OP_IMM, 12'd1, 5'd10, F3_ADD, 5'd12));
    issue_and_check(i_type(OPC_OP_IMM, 12'd5, 5'd0, F3_ADD, 5'd14));
    issue_and_check(i_type(OPC_OP_IMM, 12'hffb, 5'd0, F3_ADD, 5'd15));
    foreach (br_f3[b]) begin
      foreach (lhs[p]) begin
        r = $urandom;
        issue_and_check(b_type({r[12:1], 1'b0}, rhs[p], lhs[p], br_f3[b]));
      end
    end
    for (int n = 0; n < 4; n++) begin
      r = $urandom;
      issue_and_check(j_type({r[20:1], 1'b0}, 5'(n)));
      // odd offsets exercise the cleared bit 0
      issue_and_check(i_type(OPC_JALR, {r[31:21], n[0]}, 5'd10, 3'b000, 5'd2));
    end
  endtask

  task automatic illegal_encodings();
    load_reg(5'd7);
    issue_and_check({12'h000, 5'd1, 3'b011, 5'd7, 7'b0000011});
    issue_and_check({25'h1abcdef, 7'b1111111});
    issue_and_check(r_type(7'b0000001, 5'd2, 5'd1, F3_ADD, 5'd7));
    issue_and_check(i_type(OPC_JALR, 12'h010, 5'd1, 3'b001, 5'd7));
    issue_and_check(b_type(13'h0040, 5'd2, 5'd1, 3'b010));
    issue_and_check(32'h0000_0073);
    issue_and_check(r_type(F7_BASE, 5'd0, 5'd7, F3_ADD, 5'd5));
  endtask

  task automatic ebreak_halts();
    issue_and_check(EBREAK_WORD);
    repeat (4) begin
      strobe_while_halted(i_type(OPC_OP_IMM, 12'd1, 5'd0, F3_ADD, 5'd1));
    end
    apply_reset();
    issue_and_check(r_type(F7_BASE, 5'd0, 5'd1, F3_ADD, 5'd3));
  endtask

  initial begin
    void'($urandom(32'he5fb_a539));
    rst_n_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    pc_i         = '0;
    pc_next      = {$urandom, $urandom} & ~XLEN'(3);
    apply_reset();
    reset_reads_zero();
    random_alu_ops();
    x0_write_ignored();
    branch_and_jump();
    illegal_encodings();
    ebreak_halts();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/exu_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_core_top (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        inst_valid_i,
  input  logic [31:0]                 inst_i,
  input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
  output exu_pkg::commit_t            commit_o,
  output logic                        halted_o
);

  import rv_isa_pkg::*;
  import exu_pkg::*;

  logic [4:0]      rs1_idx;
  logic [4:0]      rs2_idx;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  exu_info_t       exu_info;
  exu_operands_t   operands;
  logic            rd_wr_en;
  logic [4:0]      rd_idx;
  logic            illegal;
  logic [XLEN-1:0] alu_res;
  logic            jump_flag;
  logic [XLEN-1:0] jump_addr;
  logic            wr_en;
  logic [4:0]      wr_idx;
  logic [XLEN-1:0] wr_data;

  idu_decoder u_idu (
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .pc_i         (pc_i),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .exu_info_o   (exu_info),
    .operands_o   (operands),
    .rd_wr_en_o   (rd_wr_en),
    .rd_idx_o     (rd_idx),
    .illegal_o    (illegal)
  );

  gpr_file u_gpr (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_idx_i  (rs1_idx),
    .rs2_idx_i  (rs2_idx),
    .wr_en_i    (wr_en),
    .wr_idx_i   (wr_idx),
    .wr_data_i  (wr_data),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  exu_alu_bjp u_exu (
    .exu_info_i  (exu_info),
    .operands_i  (operands),
    .alu_res_o   (alu_res),
    .jump_flag_o (jump_flag),
    .jump_addr_o (jump_addr)
  );

  wbu_commit u_wbu (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .exu_info_i   (exu_info),
    .rd_wr_en_i   (rd_wr_en),
    .rd_idx_i     (rd_idx),
    .illegal_i    (illegal),
    .alu_res_i    (alu_res),
    .jump_flag_i  (jump_flag),
    .jump_addr_i  (jump_addr),
    .commit_o     (commit_o),
    .halted_o     (halted_o),
    .wr_en_o      (wr_en),
    .wr_idx_o     (wr_idx),
    .wr_data_o    (wr_data)
  );

endmodule

`default_nettype wire

/* verilog/wbu_commit.sv */
`timescale 1ns/10ps
`default_nettype none

module wbu_commit (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic                        inst_valid_i,
  input  exu_pkg::exu_info_t          exu_info_i,
  input  logic                        rd_wr_en_i,
  input  logic [4:0]                  rd_idx_i,
  input  logic                        illegal_i,
  input  logic [rv_isa_pkg::XLEN-1:0] alu_res_i,
  input  logic                        jump_flag_i,
  input  logic [rv_isa_pkg::XLEN-1:0] jump_addr_i,
  output exu_pkg::commit_t            commit_o,
  output logic                        halted_o,
  output logic                        wr_en_o,
  output logic [4:0]                  wr_idx_o,
  output logic [rv_isa_pkg::XLEN-1:0] wr_data_o
);

  import rv_isa_pkg::*;

  typedef enum logic {
    RUN,
    HALT
  } state_e;

  state_e          state;
  logic            commit_en;
  logic            valid_q;
  logic            wr_q;
  logic            jump_q;
  logic            illegal_q;
  logic [4:0]      rd_idx_q;
  logic [XLEN-1:0] rd_data_q;
  logic [XLEN-1:0] jump_addr_q;

  // strobes are dropped once halted
  assign commit_en = inst_valid_i && (state == RUN);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state     <= RUN;
      valid_q   <= 1'b0;
      wr_q      <= 1'b0;
      jump_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      if (commit_en && exu_info_i.ebreak) begin
        state <= HALT;
      end
      valid_q   <= commit_en;
      wr_q      <= commit_en && rd_wr_en_i;
      jump_q    <= commit_en && jump_flag_i;
      illegal_q <= commit_en && illegal_i;
    end
  end

  always_ff @(posedge clk) begin
    if (commit_en) begin
      rd_idx_q    <= rd_idx_i;
      rd_data_q   <= alu_res_i;
      jump_addr_q <= jump_addr_i;
    end
  end

  assign commit_o = '{valid: valid_q, rd_wr_en: wr_q, rd_idx: rd_idx_q, rd_data: rd_data_q,
                      jump_flag: jump_q, jump_addr: jump_addr_q, illegal: illegal_q};

  assign halted_o = (state == HALT);

  // write lands on the same edge that registers the commit
  assign wr_en_o   = commit_en && rd_wr_en_i;
  assign wr_idx_o  = rd_idx_i;
  assign wr_data_o = alu_res_i;

  wr_not_illegal: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(commit_o.rd_wr_en && commit_o.illegal));

endmodule

`default_nettype wire

/* verilog/exu_alu_bjp.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_alu_bjp (
  input  exu_pkg::exu_info_t            exu_info_i,
  input  exu_pkg::exu_operands_t        operands_i,
  output logic [rv_isa_pkg::XLEN-1:0]   alu_res_o,
  output logic                          jump_flag_o,
  output logic [rv_isa_pkg::XLEN-1:0]   jump_addr_o
);

  import rv_isa_pkg::*;
  import exu_pkg::*;

  logic            alu_req;
  logic            bjp_req;
  logic            op_jal;
  logic            op_jalr;
  logic            op_beq;
  logic            op_bne;
  logic            op_blt;
  logic            op_bge;
  logic            op_bltu;
  logic            op_bgeu;
  logic            is_branch;
  logic            sel_add;
  logic            sel_sub;
  logic            sel_sll;
  logic            sel_slt;
  logic            sel_sltu;
  logic            sel_xor;
  logic            sel_srl;
  logic            sel_sra;
  logic            sel_or;
  logic            sel_and;
  logic            sel_lui;
  logic            adder_sub;
  logic            adder_unsigned;
  logic [XLEN:0]   adder_in1;
  logic [XLEN:0]   adder_in2;
  logic [XLEN:0]   adder_res;
  logic            lt;
  logic            eq;
  logic            br_taken;
  logic [5:0]      shamt;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] sra_res;
  logic [XLEN-1:0] target;

  assign op1   = operands_i.op1;
  assign op2   = operands_i.op2;
  assign shamt = op2[5:0];

  assign alu_req = (exu_info_i.fu == FU_ALU);
  assign bjp_req = (exu_info_i.fu == FU_BJP);

  assign op_jal    = bjp_req && exu_info_i.bjp_op == BJP_JAL;
  assign op_jalr   = bjp_req && exu_info_i.bjp_op == BJP_JALR;
  assign op_beq    = bjp_req && exu_info_i.bjp_op == BJP_BEQ;
  assign op_bne    = bjp_req && exu_info_i.bjp_op == BJP_BNE;
  assign op_blt    = bjp_req && exu_info_i.bjp_op == BJP_BLT;
  assign op_bge    = bjp_req && exu_info_i.bjp_op == BJP_BGE;
  assign op_bltu   = bjp_req && exu_info_i.bjp_op == BJP_BLTU;
  assign op_bgeu   = bjp_req && exu_info_i.bjp_op == BJP_BGEU;
  assign is_branch = op_beq | op_bne | op_blt | op_bge | op_bltu | op_bgeu;

  // jumps form their link pc + 4 in the add slot
  assign sel_add  = (alu_req && exu_info_i.alu_op == ALU_ADD) || op_jal || op_jalr;
  assign sel_sub  = alu_req && exu_info_i.alu_op == ALU_SUB;
  assign sel_sll  = alu_req && exu_info_i.alu_op == ALU_SLL;
  assign sel_slt  = alu_req && exu_info_i.alu_op == ALU_SLT;
  assign sel_sltu = alu_req && exu_info_i.alu_op == ALU_SLTU;
  assign sel_xor  = alu_req && exu_info_i.alu_op == ALU_XOR;
  assign sel_srl  = alu_req && exu_info_i.alu_op == ALU_SRL;
  assign sel_sra  = alu_req && exu_info_i.alu_op == ALU_SRA;
  assign sel_or   = alu_req && exu_info_i.alu_op == ALU_OR;
  assign sel_and  = alu_req && exu_info_i.alu_op == ALU_AND;
  assign sel_lui  = alu_req && exu_info_i.alu_op == ALU_LUI;

  // shared 65-bit adder, bit XLEN is the sign of the true difference
  assign adder_sub      = sel_sub | sel_slt | sel_sltu | is_branch;
  assign adder_unsigned = sel_sltu | op_bltu | op_bgeu;
  assign adder_in1      = {op1[XLEN-1] & ~adder_unsigned, op1};
  assign adder_in2      = {op2[XLEN-1] & ~adder_unsigned, op2} ^ {(XLEN+1){adder_sub}};
  assign adder_res      = adder_in1 + adder_in2 + {{XLEN{1'b0}}, adder_sub};

  assign lt = adder_res[XLEN];
  assign eq = (adder_res == '0);

  assign sra_res = $signed(op1) >>> shamt;

  assign alu_res_o = ({XLEN{sel_add | sel_sub}}   & adder_res[XLEN-1:0])
                   | ({XLEN{sel_sll}}             & (op1 << shamt))
                   | ({XLEN{sel_slt | sel_sltu}}  & {{(XLEN-1){1'b0}}, lt})
                   | ({XLEN{sel_xor}}             & (op1 ^ op2))
                   | ({XLEN{sel_srl}}             & (op1 >> shamt))
                   | ({XLEN{sel_sra}}             & sra_res)
                   | ({XLEN{sel_or}}              & (op1 | op2))
                   | ({XLEN{sel_and}}             & (op1 & op2))
                   | ({XLEN{sel_lui}}             & op2);

  assign br_taken = (op_beq & eq) | (op_bne & ~eq)
                  | ((op_blt | op_bltu) & lt) | ((op_bge | op_bgeu) & ~lt);

  assign jump_flag_o = op_jal | op_jalr | br_taken;

  // jalr clears bit 0 of the target
  assign target      = operands_i.op1_jp + operands_i.op2_jp;
  assign jump_addr_o = bjp_req ? {target[XLEN-1:1], target[0] & ~op_jalr} : '0;

  sel_onehot: assert final ($onehot0({sel_add, sel_sub, sel_sll, sel_slt, sel_sltu,
                                      sel_xor, sel_srl, sel_sra, sel_or, sel_and,
                                      sel_lui}));

endmodule

`default_nettype wire

/* verilog/gpr_file.sv */
`timescale 1ns/10ps
`default_nettype none

module gpr_file (
  input  logic                        clk,
  input  logic                        rst_n_i,
  input  logic [4:0]                  rs1_idx_i,
  input  logic [4:0]                  rs2_idx_i,
  input  logic                        wr_en_i,
  input  logic [4:0]                  wr_idx_i,
  input  logic [rv_isa_pkg::XLEN-1:0] wr_data_i,
  output logic [rv_isa_pkg::XLEN-1:0] rs1_data_o,
  output logic [rv_isa_pkg::XLEN-1:0] rs2_data_o
);

  import rv_isa_pkg::*;

  // x1..x31, x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_idx_i != 5'd0) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  assign rs1_data_o = (rs1_idx_i == 5'd0) ? '0 : regs[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == 5'd0) ? '0 : regs[rs2_idx_i];

  // decoder drops rd_wr_en for rd == x0
  no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_en_i |-> wr_idx_i != 5'd0);

endmodule

`default_nettype wire

/* verilog/idu_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module idu_decoder (
  input  logic                          inst_valid_i,
  input  logic [31:0]                   inst_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   pc_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   rs1_data_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   rs2_data_i,
  output logic [4:0]                    rs1_idx_o,
  output logic [4:0]                    rs2_idx_o,
  output exu_pkg::exu_info_t            exu_info_o,
  output exu_pkg::exu_operands_t        operands_o,
  output logic                          rd_wr_en_o,
  output logic [4:0]                    rd_idx_o,
  output logic                          illegal_o
);

  import rv_isa_pkg::*;
  import exu_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic            bad;
  logic            writes_rd;

  // alt selects sub or sra in the add and shift-right slots
  function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic bjp_op_e bjp_sel(input logic [2:0] f3);
    case (f3)
      F3_BNE:  return BJP_BNE;
      F3_BLT:  return BJP_BLT;
      F3_BGE:  return BJP_BGE;
      F3_BLTU: return BJP_BLTU;
      F3_BGEU: return BJP_BGEU;
      default: return BJP_BEQ;
    endcase
  endfunction

  assign opcode    = opcode_e'(inst_i[6:0]);
  assign funct3    = inst_i[14:12];
  assign funct7    = inst_i[31:25];
  assign rd_idx_o  = inst_i[11:7];
  assign rs1_idx_o = inst_i[19:15];
  assign rs2_idx_o = inst_i[24:20];

  assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {{(XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_b = {{(XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};
  assign imm_j = {{(XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};

  always_comb begin
    exu_info_o = '{fu: FU_NONE, alu_op: ALU_ADD, bjp_op: BJP_JAL, ebreak: 1'b0};
    operands_o = '{op1: rs1_data_i, op2: rs2_data_i, op1_jp: pc_i, op2_jp: imm_b};
    bad        = 1'b0;
    case (opcode)
      OPC_OP: begin
        exu_info_o.fu     = FU_ALU;
        exu_info_o.alu_op = alu_sel(funct3, funct7[5]);
        if (funct7 == F7_ALT) begin
          bad = !(funct3 == F3_ADD || funct3 == F3_SR);
        end else begin
          bad = (funct7 != F7_BASE);
        end
      end
      OPC_OP_IMM: begin
        exu_info_o.fu     = FU_ALU;
        exu_info_o.alu_op = alu_sel(funct3, inst_i[30] && funct3 == F3_SR);
        operands_o.op2    = imm_i;
        // rv64 shifts carry a 6-bit shamt, imm[11:6] is the funct
        if (funct3 == F3_SLL) begin
          bad = (inst_i[31:26] != 6'b000000);
        end else if (funct3 == F3_SR) begin
          bad = (inst_i[31:26] != 6'b000000) && (inst_i[31:26] != 6'b010000);
        end
      end
      OPC_LUI: begin
        exu_info_o.fu     = FU_ALU;
        exu_info_o.alu_op = ALU_LUI;
        operands_o.op2    = imm_u;
      end
      OPC_AUIPC: begin
        exu_info_o.fu     = FU_ALU;
        operands_o.op1    = pc_i;
        operands_o.op2    = imm_u;
      end
      OPC_JAL: begin
        exu_info_o.fu     = FU_BJP;
        operands_o.op1    = pc_i;
        operands_o.op2    = XLEN'(4);
        operands_o.op2_jp = imm_j;
      end
      OPC_JALR: begin
        exu_info_o.fu     = FU_BJP;
        exu_info_o.bjp_op = BJP_JALR;
        operands_o.op1    = pc_i;
        operands_o.op2    = XLEN'(4);
        operands_o.op1_jp = rs1_data_i;
        operands_o.op2_jp = imm_i;
        bad               = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        exu_info_o.fu     = FU_BJP;
        exu_info_o.bjp_op = bjp_sel(funct3);
        bad               = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      OPC_SYSTEM: begin
        exu_info_o.ebreak = (inst_i == EBREAK_WORD);
        bad               = (inst_i != EBREAK_WORD);
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      exu_info_o.fu = FU_NONE;
    end
  end

  // branches never write rd
  assign writes_rd = (exu_info_o.fu == FU_ALU) ||
                     (exu_info_o.fu == FU_BJP &&
                      (exu_info_o.bjp_op == BJP_JAL || exu_info_o.bjp_op == BJP_JALR));

  assign rd_wr_en_o = inst_valid_i && writes_rd && (rd_idx_o != 5'd0);
  assign illegal_o  = inst_valid_i && bad;

  illegal_no_fu: assert final (!illegal_o || (exu_info_o.fu == FU_NONE && !rd_wr_en_o));

endmodule

`default_nettype wire

/* verilog/exu_pkg.sv */
`default_nettype none

package exu_pkg;

  typedef enum logic [1:0] {
    FU_NONE,
    FU_ALU,
    FU_BJP
  } fu_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  typedef enum logic [2:0] {
    BJP_JAL, BJP_JALR, BJP_BEQ, BJP_BNE,
    BJP_BLT, BJP_BGE, BJP_BLTU, BJP_BGEU
  } bjp_op_e;

  // decoded control handed to execute and commit
  typedef struct packed {
    fu_e     fu;
    alu_op_e alu_op;
    bjp_op_e bjp_op;
    logic    ebreak;
  } exu_info_t;

  // adder operands and jump target operands
  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] op1;
    logic [rv_isa_pkg::XLEN-1:0] op2;
    logic [rv_isa_pkg::XLEN-1:0] op1_jp;
    logic [rv_isa_pkg::XLEN-1:0] op2_jp;
  } exu_operands_t;

  typedef struct packed {
    logic                        valid;
    logic                        rd_wr_en;
    logic [4:0]                  rd_idx;
    logic [rv_isa_pkg::XLEN-1:0] rd_data;
    logic                        jump_flag;
    logic [rv_isa_pkg::XLEN-1:0] jump_addr;
    logic                        illegal;
  } commit_t;

endpackage

`default_nettype wire

/* verilog/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  localparam int unsigned XLEN = 64;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // funct3 for OP and OP_IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // funct3 for BRANCH
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

endpackage

`default_nettype wire
